/* jpeg_pkg.sv */
package jpeg_pkg;

	// ==================================================
	// block geometry and widths
	// ==================================================

	// quantized coefficient width, signed
	localparam int COEF_W    = 11;
	// coefficients per 8x8 block
	localparam int BLOCK_LEN = 64;

	typedef logic signed [COEF_W-1:0] coef_t;

	// raster address or zigzag position inside one block
	typedef logic [$clog2(BLOCK_LEN)-1:0] zz_index_t;

	// zero run count, wide enough for a whole block of zeros
	typedef logic [5:0] run_t;

	// final zigzag position
	localparam zz_index_t LAST_K = zz_index_t'(BLOCK_LEN - 1);
	// zeros swallowed by one ZRL symbol
	localparam run_t ZRL_RUN = 6'd16;

	// ==================================================
	// symbol stream types
	// ==================================================

	typedef enum logic [1:0] {
		sym_dc  = 2'd0,
		sym_ac  = 2'd1,
		sym_zrl = 2'd2,
		sym_eob = 2'd3
	} sym_kind_t;

	// one coefficient tagged with its zigzag position
	typedef struct packed {
		coef_t     coef;
		zz_index_t k;
	} scan_item_t;

	// run-length symbol, 22 bits
	typedef struct packed {
		sym_kind_t  kind;
		logic [3:0] run;
		coef_t      value;
		logic       last;
		logic [3:0] pad;
	} rle_sym_t;

endpackage

/* block_buffer.sv */
`timescale 1ns/1ns

module block_buffer import jpeg_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  coef_t     coef_in,
	input  logic      coef_valid,
	input  zz_index_t rd_addr,
	output coef_t     rd_data,
	output logic      block_full
);

	// one block of coefficients, raster order
	coef_t     mem [BLOCK_LEN];
	// raster write pointer
	zz_index_t wr_cnt;

	// ==================================================
	// write side
	// ==================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_cnt     <= '0;
			block_full <= 1'b0;
		end else begin
			// pulse once the 64th coefficient has landed
			block_full <= coef_valid && (wr_cnt == LAST_K);
			if (coef_valid) begin
				// natural 6-bit wrap back to raster 0
				wr_cnt <= wr_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (coef_valid) begin
			mem[wr_cnt] <= coef_in;
		end
	end

	// ==================================================
	// read side
	// ==================================================

	// registered read, data one cycle behind the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* zigzag_scan.sv */
`timescale 1ns/1ns

module zigzag_scan import jpeg_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       block_full,
	input  logic       hold,
	input  coef_t      rd_data,
	output zz_index_t  rd_addr,
	output scan_item_t item,
	output logic       item_valid
);

	// zigzag position of the read being issued
	zz_index_t k;
	// position of the coefficient now on rd_data
	zz_index_t item_k;
	// scan counter running
	logic      active;

	// standard jpeg zigzag, position -> raster address
	// first step goes right (0 -> 1), then down-left to 8
	function automatic zz_index_t zz_lookup(input zz_index_t pos);
		case (pos)
			6'd0:  zz_lookup = 6'd0;
			6'd1:  zz_lookup = 6'd1;
			6'd2:  zz_lookup = 6'd8;
			6'd3:  zz_lookup = 6'd16;
			6'd4:  zz_lookup = 6'd9;
			6'd5:  zz_lookup = 6'd2;
			6'd6:  zz_lookup = 6'd3;
			6'd7:  zz_lookup = 6'd10;
			6'd8:  zz_lookup = 6'd17;
			6'd9:  zz_lookup = 6'd24;
			6'd10: zz_lookup = 6'd32;
			6'd11: zz_lookup = 6'd25;
			6'd12: zz_lookup = 6'd18;
			6'd13: zz_lookup = 6'd11;
			6'd14: zz_lookup = 6'd4;
			6'd15: zz_lookup = 6'd5;
			6'd16: zz_lookup = 6'd12;
			6'd17: zz_lookup = 6'd19;
			6'd18: zz_lookup = 6'd26;
			6'd19: zz_lookup = 6'd33;
			6'd20: zz_lookup = 6'd40;
			6'd21: zz_lookup = 6'd48;
			6'd22: zz_lookup = 6'd41;
			6'd23: zz_lookup = 6'd34;
			6'd24: zz_lookup = 6'd27;
			6'd25: zz_lookup = 6'd20;
			6'd26: zz_lookup = 6'd13;
			6'd27: zz_lookup = 6'd6;
			6'd28: zz_lookup = 6'd7;
			6'd29: zz_lookup = 6'd14;
			6'd30: zz_lookup = 6'd21;
			6'd31: zz_lookup = 6'd28;
			6'd32: zz_lookup = 6'd35;
			6'd33: zz_lookup = 6'd42;
			6'd34: zz_lookup = 6'd49;
			6'd35: zz_lookup = 6'd56;
			6'd36: zz_lookup = 6'd57;
			6'd37: zz_lookup = 6'd50;
			6'd38: zz_lookup = 6'd43;
			6'd39: zz_lookup = 6'd36;
			6'd40: zz_lookup = 6'd29;
			6'd41: zz_lookup = 6'd22;
			6'd42: zz_lookup = 6'd15;
			6'd43: zz_lookup = 6'd23;
			6'd44: zz_lookup = 6'd30;
			6'd45: zz_lookup = 6'd37;
			6'd46: zz_lookup = 6'd44;
			6'd47: zz_lookup = 6'd51;
			6'd48: zz_lookup = 6'd58;
			6'd49: zz_lookup = 6'd59;
			6'd50: zz_lookup = 6'd52;
			6'd51: zz_lookup = 6'd45;
			6'd52: zz_lookup = 6'd38;
			6'd53: zz_lookup = 6'd31;
			6'd54: zz_lookup = 6'd39;
			6'd55: zz_lookup = 6'd46;
			6'd56: zz_lookup = 6'd53;
			6'd57: zz_lookup = 6'd60;
			6'd58: zz_lookup = 6'd61;
			6'd59: zz_lookup = 6'd54;
			6'd60: zz_lookup = 6'd47;
			6'd61: zz_lookup = 6'd55;
			6'd62: zz_lookup = 6'd62;
			6'd63: zz_lookup = 6'd63;
		endcase
	endfunction

	// on hold re-read the item's own address so rd_data stays put
	assign rd_addr = zz_lookup(hold ? item_k : k);
	assign item    = '{coef: rd_data, k: item_k};

	// ==================================================
	// scan counter, stage 1
	// ==================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			k          <= '0;
			active     <= 1'b0;
			item_valid <= 1'b0;
		end else if (block_full) begin
			// restart at position 0
			k          <= '0;
			active     <= 1'b1;
			item_valid <= 1'b0;
		end else if (!hold) begin
			item_valid <= active;
			if (active) begin
				if (k == LAST_K) begin
					active <= 1'b0;
				end else begin
					k <= k + 1'b1;
				end
			end
		end
	end

	// position follows the read by one stage
	always_ff @(posedge clk) begin
		if (!hold) begin
			item_k <= k;
		end
	end

endmodule

/* zero_run_coder.sv */
`timescale 1ns/1ns

module zero_run_coder import jpeg_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  scan_item_t item,
	input  logic       item_valid,
	input  logic       block_full,
	output logic       hold,
	output logic       busy,
	output rle_sym_t   sym_out,
	output logic       sym_valid
);

	// zeros seen since the last coded symbol
	run_t     run_r;
	run_t     run_next;
	rle_sym_t sym_next;
	logic     emit;
	logic     busy_r;

	// item classification
	logic is_dc;
	logic is_zero;
	logic is_last;
	logic long_run;

	assign is_dc    = (item.k == '0);
	assign is_zero  = (item.coef == '0);
	assign is_last  = (item.k == LAST_K);
	assign long_run = (run_r >= ZRL_RUN);

	// stall the scan while ZRLs drain the run
	assign hold = item_valid && !is_dc && !is_zero && long_run;

	// ==================================================
	// symbol decision
	// ==================================================

	always_comb begin
		sym_next = '0;
		emit     = 1'b0;
		run_next = run_r;
		if (item_valid) begin
			if (is_dc) begin
				// dc carries the raw coefficient
				sym_next.kind  = sym_dc;
				sym_next.value = item.coef;
				emit           = 1'b1;
			end else if (is_zero) begin
				if (is_last) begin
					// block ends in zeros
					sym_next.kind = sym_eob;
					sym_next.last = 1'b1;
					emit          = 1'b1;
					run_next      = '0;
				end else begin
					run_next = run_r + 1'b1;
				end
			end else if (long_run) begin
				// sixteen zeros per ZRL, item repeats under hold
				sym_next.kind = sym_zrl;
				sym_next.run  = 4'(ZRL_RUN - 1'b1);
				emit          = 1'b1;
				run_next      = run_r - ZRL_RUN;
			end else begin
				// remainder of run fits the 4-bit field
				sym_next.kind  = sym_ac;
				sym_next.run   = run_r[3:0];
				sym_next.value = item.coef;
				sym_next.last  = is_last;
				emit           = 1'b1;
				run_next       = '0;
			end
		end
	end

	// ==================================================
	// state and output register
	// ==================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_r     <= '0;
			sym_valid <= 1'b0;
			busy_r    <= 1'b0;
		end else begin
			sym_valid <= emit;
			run_r     <= block_full ? '0 : run_next;
			// drop busy once the last symbol has been shown
			if (block_full) begin
				busy_r <= 1'b1;
			end else if (sym_valid && sym_out.last) begin
				busy_r <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			sym_out <= sym_next;
		end
	end

	// busy already high in the block_full cycle
	assign busy = busy_r | block_full;

endmodule

/* jpeg_rle_encoder.sv */
`timescale 1ns/1ns

module jpeg_rle_encoder import jpeg_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  coef_t    coef_in,
	input  logic     coef_valid,
	output rle_sym_t sym_out,
	output logic     sym_valid,
	output logic     busy
);

	// buffer <-> scanner
	logic       block_full;
	coef_t      rd_data;
	zz_index_t  rd_addr;
	// scanner <-> coder
	scan_item_t item;
	logic       item_valid;
	logic       hold;

	// raster collection of one block
	block_buffer u_block_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.coef_in    (coef_in),
		.coef_valid (coef_valid),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.block_full (block_full)
	);

	// zigzag readback
	zigzag_scan u_zigzag_scan (
		.clk        (clk),
		.rst_n      (rst_n),
		.block_full (block_full),
		.hold       (hold),
		.rd_data    (rd_data),
		.rd_addr    (rd_addr),
		.item       (item),
		.item_valid (item_valid)
	);

	// dc / ac / zrl / eob symbols
	zero_run_coder u_zero_run_coder (
		.clk        (clk),
		.rst_n      (rst_n),
		.item       (item),
		.item_valid (item_valid),
		.block_full (block_full),
		.hold       (hold),
		.busy       (busy),
		.sym_out    (sym_out),
		.sym_valid  (sym_valid)
	);

endmodule

/* jpeg_rle_chk.sv */
`timescale 1ns/1ns

module jpeg_rle_chk import jpeg_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     coef_valid,
	input logic     sym_valid,
	input logic     busy,
	input rle_sym_t sym_out
);

	// sticky marks, one per property
	logic idle_sym_hit   = 1'b0;
	logic busy_write_hit = 1'b0;
	logic zrl_form_hit   = 1'b0;
	// any property has failed so far
	logic fired;

	assign fired = idle_sym_hit | busy_write_hit | zrl_form_hit;

	// ==================================================
	// protocol properties
	// ==================================================

	// symbols only inside a block
	sym_needs_busy: assert property (
		@(posedge clk) disable iff (!rst_n) sym_valid |-> busy
	) else begin
		idle_sym_hit = 1'b1;
		$error("symbol strobe while the encoder is idle");
	end

	// source stays quiet while a block is coded
	no_write_when_busy: assert property (
		@(posedge clk) disable iff (!rst_n) busy |-> !coef_valid
	) else begin
		busy_write_hit = 1'b1;
		$error("coefficient written while the encoder is busy");
	end

	// zrl always codes fifteen zeros plus a zero value
	zrl_shape: assert property (
		@(posedge clk) disable iff (!rst_n)
		(sym_valid && sym_out.kind == sym_zrl) |-> (sym_out.run == 4'd15 && sym_out.value == '0)
	) else begin
		zrl_form_hit = 1'b1;
		$error("ZRL symbol with wrong run or value");
	end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	// free running testbench clock
	// 8 ns period, 4 ns per half
	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

endmodule

/* tb_jpeg_rle.sv */
`timescale 1ns/1ns

module tb_jpeg_rle import jpeg_pkg::*; ();

	// blocks in the whole run
	localparam int NUM_BLOCKS   = 14;
	// write, scan and up to four ZRL cycles per block
	localparam int BLOCK_CYCLES = BLOCK_LEN + 70 + 4;
	localparam int CYCLE_LIMIT  = NUM_BLOCKS * BLOCK_CYCLES + 100;

	logic     clk;
	logic     rst_n;
	coef_t    coef_in;
	logic     coef_valid;
	rle_sym_t sym_out;
	logic     sym_valid;
	logic     busy;

	// block under test in raster order
	coef_t     blk [BLOCK_LEN];
	// raster address for each zigzag position
	zz_index_t zz_order [BLOCK_LEN];
	// expected symbols with the oldest first
	rle_sym_t  exp_q [$];
	string     test_name = "reset";
	logic [31:0] lcg_state;
	int        sym_count = 0;
	int        cycle_cnt = 0;

	tb_clock u_clock (
		.clk (clk)
	);

	jpeg_rle_encoder UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.coef_in    (coef_in),
		.coef_valid (coef_valid),
		.sym_out    (sym_out),
		.sym_valid  (sym_valid),
		.busy       (busy)
	);

	bind jpeg_rle_encoder jpeg_rle_chk u_chk (
		.clk        (clk),
		.rst_n      (rst_n),
		.coef_valid (coef_valid),
		.sym_valid  (sym_valid),
		.busy       (busy),
		.sym_out    (sym_out)
	);

	// ==================================================
	// helpers
	// ==================================================

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic string sym_text(input rle_sym_t s);
		return $sformatf("%s run=%0d value=%0d last=%b pad=%h",
			s.kind.name(), s.run, s.value, s.last, s.pad);
	endfunction

	task automatic check_sym(input string name, input int idx, input rle_sym_t exp,
		input rle_sym_t act);
		if (act !== exp) begin
			report_failure($sformatf("error: %s symbol %0d expected %s actual %s",
				name, idx, sym_text(exp), sym_text(act)));
		end
	endtask

	task automatic check_level(input string name, input string what, input logic exp,
		input logic act);
		if (act !== exp) begin
			report_failure($sformatf("error: %s %s expected %b actual %b",
				name, what, exp, act));
		end
	endtask

	// walk the anti-diagonals in alternating direction
	task automatic build_zigzag();
		int pos;
		int s;
		int r;
		pos = 0;
		for (s = 0; s < 15; s++) begin
			if (s % 2 == 0) begin
				// even diagonal climbs with the row falling
				for (r = (s < 8) ? s : 7; r >= 0 && s - r < 8; r--) begin
					zz_order[zz_index_t'(pos)] = zz_index_t'(r * 8 + s - r);
					pos++;
				end
			end else begin
				// odd diagonal descends with the row rising
				for (r = (s < 8) ? 0 : s - 7; r <= s && r < 8; r++) begin
					zz_order[zz_index_t'(pos)] = zz_index_t'(r * 8 + s - r);
					pos++;
				end
			end
		end
	endtask

	function automatic rle_sym_t make_sym(input sym_kind_t kind, input logic [3:0] run,
		input coef_t value, input logic last);
		rle_sym_t s;
		s       = '0;
		s.kind  = kind;
		s.run   = run;
		s.value = value;
		s.last  = last;
		return s;
	endfunction

	// ==================================================
	// reference model
	// ==================================================

	task automatic predict_block();
		int    k;
		int    run;
		coef_t v;
		// dc is the raster-0 coefficient as is
		exp_q.push_back(make_sym(sym_dc, 4'd0, blk[0], 1'b0));
		run = 0;
		for (k = 1; k < BLOCK_LEN; k++) begin
			v = blk[zz_order[zz_index_t'(k)]];
			if (v == '0) begin
				if (k == BLOCK_LEN - 1) begin
					exp_q.push_back(make_sym(sym_eob, 4'd0, '0, 1'b1));
				end else begin
					run++;
				end
			end else begin
				// one zrl per sixteen zeros
				while (run >= int'(ZRL_RUN)) begin
					exp_q.push_back(make_sym(sym_zrl, 4'd15, '0, 1'b0));
					run -= int'(ZRL_RUN);
				end
				exp_q.push_back(make_sym(sym_ac, 4'(run), v, k == BLOCK_LEN - 1));
				run = 0;
			end
		end
	endtask

	// ==================================================
	// stimulus
	// ==================================================

	task automatic clear_block();
		int i;
		for (i = 0; i < BLOCK_LEN; i++) begin
			blk[zz_index_t'(i)] = '0;
		end
	endtask

	// zero when the top nibble is below zero_lim
	task automatic fill_block(input logic [3:0] zero_lim);
		int    i;
		coef_t v;
		for (i = 0; i < BLOCK_LEN; i++) begin
			lcg_state = lcg_next(lcg_state);
			v = coef_t'(lcg_state[26:16]);
			if (v == '0) begin
				v = coef_t'(1);
			end
			if (lcg_state[31:28] < zero_lim) begin
				blk[zz_index_t'(i)] = '0;
			end else begin
				blk[zz_index_t'(i)] = v;
			end
		end
	endtask

	task automatic run_block(input string name);
		int i;
		test_name = name;
		predict_block();
		// 64 back to back writes into an idle encoder
		for (i = 0; i < BLOCK_LEN; i++) begin
			@(negedge clk);
			check_level(name, "busy before block full", 1'b0, busy);
			check_level(name, "sym_valid before block full", 1'b0, sym_valid);
			coef_valid = 1'b1;
			coef_in    = blk[zz_index_t'(i)];
		end
		@(negedge clk);
		coef_valid = 1'b0;
		coef_in    = '0;
		// wait for the symbol flagged last
		while (!(sym_valid && sym_out.last)) begin
			@(negedge clk);
		end
		@(negedge clk);
		check_level(name, "busy after last symbol", 1'b0, busy);
		check_level(name, "sym_valid after last symbol", 1'b0, sym_valid);
		if (exp_q.size() != 0) begin
			report_failure($sformatf("%s ended with %0d expected symbols never produced",
				name, exp_q.size()));
		end
	endtask

	initial begin
		int n;
		rst_n      = 1'b0;
		coef_valid = 1'b0;
		coef_in    = '0;
		lcg_state  = 32'd83;
		build_zigzag();
		// two rising edges under reset
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// dc then eob only
		clear_block();
		run_block("all_zero");
		clear_block();
		blk[0] = coef_t'(-37);
		run_block("dc_only");
		// 62 zeros give three zrl then ac run 14 with last
		clear_block();
		blk[0] = coef_t'(5);
		blk[zz_order[LAST_K]] = coef_t'(-2);
		run_block("last_only");
		// exactly sixteen zeros before position 17
		clear_block();
		blk[0] = coef_t'(100);
		blk[zz_order[6'd17]] = coef_t'(9);
		run_block("run_16");
		// no zeros at all
		fill_block(4'd0);
		run_block("dense");
		for (n = 0; n < 4; n++) begin
			fill_block(4'd15);
			run_block("random_sparse");
		end
		for (n = 0; n < 5; n++) begin
			fill_block(4'd12);
			run_block("random_mixed");
		end
		$display("test passed");
		$finish;
	end

	// ==================================================
	// output monitor and timeout
	// ==================================================

	// symbols popped and compared in the middle of the cycle
	always @(negedge clk) begin
		if (UUT.u_chk.fired) begin
			report_failure("a bound protocol assertion failed");
		end else if (rst_n && sym_valid && exp_q.size() == 0) begin
			report_failure($sformatf("%s produced a symbol that was not expected", test_name));
		end else if (rst_n && sym_valid) begin
			sym_count++;
			check_sym(test_name, sym_count, exp_q.pop_front(), sym_out);
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			report_failure($sformatf("encoder did not finish all blocks within %0d cycles",
				CYCLE_LIMIT));
		end
	end

endmodule

/* files.f */
jpeg_pkg.sv
block_buffer.sv
zigzag_scan.sv
zero_run_coder.sv
jpeg_rle_encoder.sv
jpeg_rle_chk.sv
tb_clock.sv
tb_jpeg_rle.sv

/* Makefile */
TOP = tb_jpeg_rle

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
